// File: source/wb_mem_pkg.sv
package wb_mem_pkg;

  // Bus widths.
  localparam int WB_ADR_W   = 32;
  localparam int WB_DAT_W   = 16;
  localparam int WB_SEL_W   = 2;
  localparam int BANK_ADR_W = 11;

  typedef logic [WB_ADR_W-1:0]   wb_adr_t;
  typedef logic [WB_DAT_W-1:0]   wb_dat_t;
  typedef logic [WB_SEL_W-1:0]   wb_sel_t;
  typedef logic [BANK_ADR_W-1:0] bank_adr_t;

  // One bank is addressed by byte address bits 11 down to 1.
  localparam int BANK_WORDS = 2048;

  // The region field sits in the top nibble of the byte address.
  localparam int REGION_MSB = 31;
  localparam int REGION_LSB = 28;

  typedef logic [REGION_MSB-REGION_LSB:0] region_t;

  localparam region_t MEM_REGION = 4'd0;
  localparam region_t REG_REGION = 4'd1;

  // Identification word returned at register offset 0.
  localparam wb_dat_t SUBSYS_ID = 16'hB7A5;

endpackage

// File: source/bram_bank.sv
`timescale 1ns/10ps

module bram_bank (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  input  wb_mem_pkg::bank_adr_t addr_i,
  input  wb_mem_pkg::wb_dat_t   wdata_i,
  input  wb_mem_pkg::wb_sel_t   we_i,
  output wb_mem_pkg::wb_dat_t   rdata_o
);

  import wb_mem_pkg::*;

  wb_dat_t mem [BANK_WORDS];

  // Byte-lane writes into the array.
  always_ff @(posedge wb_clk_i) begin
    if (we_i[0]) begin
      mem[addr_i][7:0] <= wdata_i[7:0];
    end
    if (we_i[1]) begin
      mem[addr_i][15:8] <= wdata_i[15:8];
    end
  end

  // Write-first read port: a written lane shows the new value on the next cycle.
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      rdata_o <= '0;
    end else begin
      rdata_o[7:0]  <= we_i[0] ? wdata_i[7:0]  : mem[addr_i][7:0];
      rdata_o[15:8] <= we_i[1] ? wdata_i[15:8] : mem[addr_i][15:8];
    end
  end

endmodule

// File: source/bram_controller.sv
`timescale 1ns/10ps

module bram_controller #(
  parameter int RAM_SIZE_K = 8
) (
  input  logic                wb_clk_i,
  input  logic                wb_rst_i,
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  wb_mem_pkg::wb_sel_t wb_sel_i,
  input  wb_mem_pkg::wb_adr_t wb_adr_i,
  input  wb_mem_pkg::wb_dat_t wb_dat_i,
  output wb_mem_pkg::wb_dat_t wb_dat_o,
  output logic                wb_ack_o
);

  import wb_mem_pkg::*;

  // Each bank holds 4 KB, so the count is the size over 4 rounded up.
  localparam int NUM_BANKS    = (RAM_SIZE_K + 3) / 4;
  localparam int BANK_SEL_W   = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;
  localparam int BANK_SEL_LSB = BANK_ADR_W + 1;

  function automatic wb_dat_t bit_reverse(input wb_dat_t d);
    wb_dat_t r;
    for (int i = 0; i < WB_DAT_W; i++) begin
      r[i] = d[WB_DAT_W-1-i];
    end
    return r;
  endfunction

  logic                  wb_trans;
  logic                  wr_accept;
  logic [BANK_SEL_W-1:0] raw_sel;
  logic [BANK_SEL_W-1:0] bank_sel;
  logic [BANK_SEL_W-1:0] bank_sel_q;
  bank_adr_t             bank_adr;
  wb_dat_t               bank_wdata;
  wb_dat_t               bank_rdata [NUM_BANKS];
  wb_sel_t               bank_we    [NUM_BANKS];

  // A new access starts only while ack is low, so a held strobe is not seen twice.
  assign wb_trans  = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr_accept = wb_trans & wb_we_i;

  assign bank_adr   = wb_adr_i[BANK_ADR_W:1];
  assign bank_wdata = bit_reverse(wb_dat_i);

  // Select bits that point past the last bank fold back onto the existing ones.
  assign raw_sel  = wb_adr_i[BANK_SEL_LSB +: BANK_SEL_W];
  assign bank_sel = BANK_SEL_W'(raw_sel % NUM_BANKS);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o   <= 1'b0;
      bank_sel_q <= '0;
    end else begin
      wb_ack_o <= wb_trans;
      if (wb_trans) begin
        bank_sel_q <= bank_sel;
      end
    end
  end

  // Since data is stored reversed, sel bit 0 lands on the stored low byte,
  // which carries the external high byte.
  for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
    assign bank_we[g] = (wr_accept && bank_sel == BANK_SEL_W'(g)) ? wb_sel_i : '0;

    bram_bank u_bank (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .addr_i   (bank_adr),
      .wdata_i  (bank_wdata),
      .we_i     (bank_we[g]),
      .rdata_o  (bank_rdata[g])
    );
  end

  // The bank output register and the select copy line up with the ack cycle.
  assign wb_dat_o = bit_reverse(bank_rdata[bank_sel_q]);

endmodule

// File: source/wb_addr_decoder.sv
`timescale 1ns/10ps

module wb_addr_decoder (
  input  logic                wb_clk_i,
  input  logic                wb_rst_i,
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  wb_mem_pkg::wb_adr_t wb_adr_i,
  input  logic                mem_ack_i,
  input  wb_mem_pkg::wb_dat_t mem_dat_i,
  input  logic                reg_ack_i,
  input  wb_mem_pkg::wb_dat_t reg_dat_i,
  output logic                mem_stb_o,
  output logic                reg_stb_o,
  output logic                mem_wr_done_o,
  output logic                wb_ack_o,
  output wb_mem_pkg::wb_dat_t wb_dat_o
);

  import wb_mem_pkg::*;

  region_t region;
  logic    mem_hit;
  logic    reg_hit;
  logic    unmapped_hit;
  logic    bus_req;
  logic    unmapped_ack_q;

  assign region       = wb_adr_i[REGION_MSB:REGION_LSB];
  assign mem_hit      = (region == MEM_REGION);
  assign reg_hit      = (region == REG_REGION);
  assign unmapped_hit = ~mem_hit & ~reg_hit;

  assign bus_req   = wb_cyc_i & wb_stb_i;
  assign mem_stb_o = bus_req & mem_hit;
  assign reg_stb_o = bus_req & reg_hit;

  // Accesses outside both regions still complete in one cycle.
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      unmapped_ack_q <= 1'b0;
    end else begin
      unmapped_ack_q <= bus_req & unmapped_hit & ~unmapped_ack_q;
    end
  end

  // The master holds the address through ack, so the live region picks the return path.
  always_comb begin
    if (mem_hit) begin
      wb_ack_o = mem_ack_i;
      wb_dat_o = mem_dat_i;
    end else if (reg_hit) begin
      wb_ack_o = reg_ack_i;
      wb_dat_o = reg_dat_i;
    end else begin
      wb_ack_o = unmapped_ack_q;
      wb_dat_o = '0;
    end
  end

  // One pulse per completed memory write, as the memory ack lasts one cycle.
  assign mem_wr_done_o = mem_ack_i & mem_hit & wb_cyc_i & wb_we_i;

endmodule

// File: source/wb_sys_regs.sv
`timescale 1ns/10ps

module wb_sys_regs (
  input  logic                wb_clk_i,
  input  logic                wb_rst_i,
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  wb_mem_pkg::wb_sel_t wb_sel_i,
  input  wb_mem_pkg::wb_adr_t wb_adr_i,
  input  wb_mem_pkg::wb_dat_t wb_dat_i,
  input  logic                mem_wr_done_i,
  output wb_mem_pkg::wb_dat_t wb_dat_o,
  output logic                wb_ack_o
);

  import wb_mem_pkg::*;

  // Word offsets, taken from byte address bits 2 and 1.
  localparam logic [1:0] OFS_ID      = 2'd0;
  localparam logic [1:0] OFS_SCRATCH = 2'd1;
  localparam logic [1:0] OFS_COUNT   = 2'd2;

  logic       wb_trans;
  logic       wr_accept;
  logic [1:0] reg_offset;
  wb_dat_t    scratch_q;
  wb_dat_t    wr_count_q;

  assign wb_trans   = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr_accept  = wb_trans & wb_we_i;
  assign reg_offset = wb_adr_i[2:1];

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= wb_trans;
    end
  end

  // Scratch takes byte lanes as they arrive, with no reversal.
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      scratch_q <= '0;
    end else if (wr_accept && reg_offset == OFS_SCRATCH) begin
      if (wb_sel_i[0]) begin
        scratch_q[7:0] <= wb_dat_i[7:0];
      end
      if (wb_sel_i[1]) begin
        scratch_q[15:8] <= wb_dat_i[15:8];
      end
    end
  end

  // A write clears the count. A memory write in the same cycle still counts.
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wr_count_q <= '0;
    end else if (wr_accept && reg_offset == OFS_COUNT) begin
      wr_count_q <= mem_wr_done_i ? wb_dat_t'(1) : '0;
    end else if (mem_wr_done_i) begin
      wr_count_q <= wr_count_q + wb_dat_t'(1);
    end
  end

  always_comb begin
    case (reg_offset)
      OFS_ID:      wb_dat_o = SUBSYS_ID;
      OFS_SCRATCH: wb_dat_o = scratch_q;
      OFS_COUNT:   wb_dat_o = wr_count_q;
      default:     wb_dat_o = '0;
    endcase
  end

endmodule

// File: source/wb_mem_subsystem.sv
`timescale 1ns/10ps

module wb_mem_subsystem #(
  parameter int RAM_SIZE_K = 8
) (
  input  logic                wb_clk_i,
  input  logic                wb_rst_i,
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  wb_mem_pkg::wb_sel_t wb_sel_i,
  input  wb_mem_pkg::wb_adr_t wb_adr_i,
  input  wb_mem_pkg::wb_dat_t wb_dat_i,
  output wb_mem_pkg::wb_dat_t wb_dat_o,
  output logic                wb_ack_o
);

  import wb_mem_pkg::*;

  logic    mem_stb;
  logic    mem_ack;
  wb_dat_t mem_dat;
  logic    reg_stb;
  logic    reg_ack;
  wb_dat_t reg_dat;
  logic    mem_wr_done;

  wb_addr_decoder u_decoder (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .mem_ack_i     (mem_ack),
    .mem_dat_i     (mem_dat),
    .reg_ack_i     (reg_ack),
    .reg_dat_i     (reg_dat),
    .mem_stb_o     (mem_stb),
    .reg_stb_o     (reg_stb),
    .mem_wr_done_o (mem_wr_done),
    .wb_ack_o      (wb_ack_o),
    .wb_dat_o      (wb_dat_o)
  );

  // Memory region.
  bram_controller #(
    .RAM_SIZE_K (RAM_SIZE_K)
  ) u_bram_ctrl (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (mem_stb),
    .wb_we_i  (wb_we_i),
    .wb_sel_i (wb_sel_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (mem_dat),
    .wb_ack_o (mem_ack)
  );

  // Register region.
  wb_sys_regs u_sys_regs (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (reg_stb),
    .wb_we_i       (wb_we_i),
    .wb_sel_i      (wb_sel_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .mem_wr_done_i (mem_wr_done),
    .wb_dat_o      (reg_dat),
    .wb_ack_o      (reg_ack)
  );

endmodule

// File: verification/wb_mem_subsystem_tb.sv
`timescale 1ns/10ps

module wb_mem_subsystem_tb;

  import wb_mem_pkg::*;

  localparam int      CLK_PERIOD = 8;
  localparam int      TEST_COUNT = 80;
  localparam int      ACK_LIMIT  = 8;
  localparam int      RAND_WORDS = 16;
  localparam wb_adr_t REG_BASE   = 32'h1000_0000;

  logic    wb_clk_i;
  logic    wb_rst_i;
  logic    wb_cyc_i;
  logic    wb_stb_i;
  logic    wb_we_i;
  wb_sel_t wb_sel_i;
  wb_adr_t wb_adr_i;
  wb_dat_t wb_dat_i;
  wb_dat_t wb_dat_o;
  logic    wb_ack_o;

  // Reference model state.
  wb_dat_t mem_model [logic [11:0]];
  wb_dat_t scratch_m;
  wb_dat_t count_m;

  wb_dat_t exp_dat;
  logic    rd_pending;
  logic    new_req;
  int      errors;
  int      seed;
  wb_adr_t rand_adrs [$];

  wb_mem_subsystem #(
    .RAM_SIZE_K (8)
  ) dut0 (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_sel_i (wb_sel_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
  );

  always #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;

  assign new_req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  task automatic value_error(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    errors++;
    $display("** Error: %s = 0x%h, expected 0x%h at %0t ns", name, got, expected, $time);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first mismatch.");
  endtask

  ack_low_in_reset: assert property (@(posedge wb_clk_i) wb_rst_i |=> !wb_ack_o)
    else value_error("wb_ack_o", 32'($sampled(wb_ack_o)), 32'h0);

  ack_after_req: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    new_req |=> wb_ack_o)
    else value_error("wb_ack_o", 32'($sampled(wb_ack_o)), 32'h1);

  ack_one_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o)
    else value_error("wb_ack_o", 32'($sampled(wb_ack_o)), 32'h0);

  ack_needs_req: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |-> $past(new_req))
    else value_error("wb_ack_o", 32'($sampled(wb_ack_o)), 32'h0);

  read_data_ok: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (wb_ack_o && rd_pending) |-> (wb_dat_o == exp_dat))
    else value_error("wb_dat_o", 32'($sampled(wb_dat_o)), 32'($sampled(exp_dat)));

  // One classic Wishbone cycle. Request signals are held until ack is seen.
  task automatic bus_access(input wb_adr_t adr, input logic we, input wb_sel_t sel,
                            input wb_dat_t dat, input logic check, input wb_dat_t expected);
    int waited;
    waited = 0;
    @(posedge wb_clk_i);
    #1;
    wb_adr_i   = adr;
    wb_we_i    = we;
    wb_sel_i   = sel;
    wb_dat_i   = dat;
    exp_dat    = expected;
    rd_pending = check;
    wb_cyc_i   = 1'b1;
    wb_stb_i   = 1'b1;
    @(negedge wb_clk_i);
    while (!wb_ack_o && waited < ACK_LIMIT) begin
      @(negedge wb_clk_i);
      waited++;
    end
    if (!wb_ack_o) begin
      $display("No ack arrived for the access to address 0x%h.", adr);
      $display("ERRORS FOUND");
      $fatal(1, "Bus access timed out.");
    end else begin
      @(posedge wb_clk_i);
      #1;
      wb_cyc_i   = 1'b0;
      wb_stb_i   = 1'b0;
      wb_we_i    = 1'b0;
      rd_pending = 1'b0;
    end
  endtask

  task automatic mem_write(input wb_adr_t adr, input wb_dat_t dat, input wb_sel_t sel);
    wb_dat_t word;
    word = mem_model.exists(adr[12:1]) ? mem_model[adr[12:1]] : 16'h0000;
    // Data is stored reversed, so sel bit 0 reaches the external high byte.
    if (sel[0]) begin
      word[15:8] = dat[15:8];
    end
    if (sel[1]) begin
      word[7:0] = dat[7:0];
    end
    mem_model[adr[12:1]] = word;
    count_m = count_m + 16'd1;
    bus_access(adr, 1'b1, sel, dat, 1'b0, 16'h0000);
  endtask

  task automatic mem_read(input wb_adr_t adr);
    bus_access(adr, 1'b0, 2'b11, 16'h0000, 1'b1, mem_model[adr[12:1]]);
  endtask

  task automatic reg_write(input logic [2:0] offset, input wb_dat_t dat, input wb_sel_t sel);
    if (offset == 3'd2) begin
      if (sel[0]) begin
        scratch_m[7:0] = dat[7:0];
      end
      if (sel[1]) begin
        scratch_m[15:8] = dat[15:8];
      end
    end else if (offset == 3'd4) begin
      count_m = 16'h0000;
    end
    bus_access(REG_BASE | wb_adr_t'(offset), 1'b1, sel, dat, 1'b0, 16'h0000);
  endtask

  task automatic reg_read(input logic [2:0] offset);
    wb_dat_t expected;
    case (offset)
      3'd0:    expected = 16'hB7A5;
      3'd2:    expected = scratch_m;
      3'd4:    expected = count_m;
      default: expected = 16'h0000;
    endcase
    bus_access(REG_BASE | wb_adr_t'(offset), 1'b0, 2'b11, 16'h0000, 1'b1, expected);
  endtask

  task automatic unmapped_access(input wb_adr_t adr, input logic we, input wb_dat_t dat);
    bus_access(adr, we, 2'b11, dat, ~we, 16'h0000);
  endtask

  // Each access takes about three cycles, well inside the per-test allowance.
  initial begin
    #(TEST_COUNT * 20 * CLK_PERIOD + 100 * CLK_PERIOD);
    $display("Watchdog expired before the tests completed.");
    $display("ERRORS FOUND");
    $fatal(1, "Simulation timed out.");
  end

  initial begin
    wb_adr_t adr;
    wb_dat_t dat;
    wb_clk_i   = 1'b0;
    wb_rst_i   = 1'b1;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_sel_i   = 2'b00;
    wb_adr_i   = '0;
    wb_dat_i   = '0;
    exp_dat    = '0;
    rd_pending = 1'b0;
    scratch_m  = '0;
    count_m    = '0;
    errors     = 0;
    seed       = 32'h7081;

    repeat (3) @(posedge wb_clk_i);
    #1;
    wb_rst_i = 1'b0;

    // Random full-word traffic across both banks.
    for (int i = 0; i < RAND_WORDS; i++) begin
      adr = $random(seed) & 32'h0000_1FFE;
      dat = wb_dat_t'($random(seed));
      rand_adrs.push_back(adr);
      mem_write(adr, dat, 2'b11);
    end
    foreach (rand_adrs[i]) begin
      mem_read(rand_adrs[i]);
    end

    // The same word offset in each bank keeps its own value.
    mem_write(32'h0000_02AA, 16'h1234, 2'b11);
    mem_write(32'h0000_12AA, 16'hEDCB, 2'b11);
    mem_write(32'h0000_0554, 16'h6C39, 2'b11);
    mem_write(32'h0000_1554, 16'h93C6, 2'b11);
    mem_read(32'h0000_02AA);
    mem_read(32'h0000_12AA);
    mem_read(32'h0000_0554);
    mem_read(32'h0000_1554);

    // Byte lanes through the reversed storage.
    mem_write(32'h0000_0100, 16'hA5C3, 2'b11);
    mem_write(32'h0000_0100, 16'h5A3C, 2'b01);
    mem_read(32'h0000_0100);
    mem_write(32'h0000_0100, 16'h0F0F, 2'b10);
    mem_read(32'h0000_0100);

    // Registers.
    reg_read(3'd0);
    reg_write(3'd2, 16'h1357, 2'b11);
    reg_read(3'd2);
    reg_write(3'd2, 16'hAB00, 2'b10);
    reg_read(3'd2);
    reg_write(3'd2, 16'h00CD, 2'b01);
    reg_read(3'd2);
    reg_read(3'd6);
    reg_read(3'd4);
    reg_write(3'd4, 16'hFFFF, 2'b11);
    reg_read(3'd4);
    mem_write(32'h0000_0200, 16'h0001, 2'b11);
    mem_write(32'h0000_1200, 16'h0002, 2'b11);
    mem_write(32'h0000_0202, 16'h0003, 2'b01);
    reg_read(3'd4);

    // Unmapped regions answer with zero and leave everything else alone.
    unmapped_access(32'h2000_0100, 1'b1, 16'hFFFF);
    unmapped_access(32'h3000_0004, 1'b1, 16'hFFFF);
    unmapped_access(32'h2000_0100, 1'b0, 16'h0000);
    unmapped_access(32'hF000_0002, 1'b0, 16'h0000);
    mem_read(32'h0000_0100);
    reg_read(3'd2);
    reg_read(3'd4);

    repeat (2) @(posedge wb_clk_i);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: sources.f
source/wb_mem_pkg.sv
source/bram_bank.sv
source/bram_controller.sv
source/wb_addr_decoder.sv
source/wb_sys_regs.sv
source/wb_mem_subsystem.sv
verification/wb_mem_subsystem_tb.sv
